//--- rtl/soc_bus_pkg.sv
// Bus widths, request and response structs, slave indices and address windows
`default_nettype none

package soc_bus_pkg;

  typedef logic [15:0] data_t;
  typedef logic [18:0] word_adr_t;
  typedef logic [1:0]  sel_t;
  typedef logic [9:0]  sw_t;
  typedef logic [13:0] leds_t;

  // Decode address is the io tag followed by the word address
  typedef logic [19:0] dec_adr_t;

  typedef struct packed {
    word_adr_t adr;
    logic      io;
    data_t     dat;
    sel_t      sel;
    logic      we;
    logic      cyc;
    logic      stb;
  } bus_req_t;

  typedef struct packed {
    data_t dat;
    logic  ack;
  } bus_rsp_t;

  localparam int SLAVE_COUNT = 3;
  typedef logic [SLAVE_COUNT-1:0] slv_sel_t;

  // Bit positions in the one-hot select, highest priority first
  localparam int SLV_GPIO = 0;
  localparam int SLV_RAM  = 1;
  localparam int SLV_DEF  = 2;

  // io 0xf100 - 0xf103
  localparam dec_adr_t GPIO_BASE = 20'b1_0000_1111_0001_0000_000;
  localparam dec_adr_t GPIO_MASK = 20'b1_1111_1111_1111_1111_110;
  // Whole memory space
  localparam dec_adr_t RAM_BASE  = 20'b0_0000_0000_0000_0000_000;
  localparam dec_adr_t RAM_MASK  = 20'b1_0000_0000_0000_0000_000;

endpackage

`default_nettype wire

//--- rtl/rst_debounce.sv
// Power-on reset debouncer with a down counter and registered reset output
`timescale 1ns/1ps
`default_nettype none

module rst_debounce #(
  parameter int RST_COUNT_BITS = 17
) (
  input  logic clk,
  input  logic rst_lck,
  output logic rst_n_int_o
);

  logic [RST_COUNT_BITS-1:0] cnt;

  // Reload while the external line is low, then run down to zero
  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      cnt <= '1;
    end else if (cnt != '0) begin
      cnt <= cnt - 1'b1;
    end
  end

  // Release one cycle after the count is spent
  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      rst_n_int_o <= 1'b0;
    end else begin
      rst_n_int_o <= (cnt == '0);
    end
  end

endmodule

`default_nettype wire

//--- rtl/bus_switch.sv
// Address window decoder, request routing, response mux and default slave
`timescale 1ns/1ps
`default_nettype none

module bus_switch import soc_bus_pkg::*; (
  input  logic     clk,
  input  logic     rst_n_i,
  input  bus_req_t m_req_i,
  output bus_rsp_t m_rsp_o,
  output bus_req_t ram_req_o,
  input  bus_rsp_t ram_rsp_i,
  output bus_req_t gpio_req_o,
  input  bus_rsp_t gpio_rsp_i
);

  dec_adr_t dec_adr;
  slv_sel_t sel_now;
  slv_sel_t sel_q;
  slv_sel_t sel;
  logic     cyc_q;
  logic     def_ack;

  function automatic logic win_hit(dec_adr_t adr, dec_adr_t base, dec_adr_t mask);
    return ((adr ^ base) & mask) == '0;
  endfunction

  assign dec_adr = {m_req_i.io, m_req_i.adr};

  // Priority decode, GPIO before memory
  always_comb begin
    sel_now = '0;
    if (win_hit(dec_adr, GPIO_BASE, GPIO_MASK)) begin
      sel_now[SLV_GPIO] = 1'b1;
    end else if (win_hit(dec_adr, RAM_BASE, RAM_MASK)) begin
      sel_now[SLV_RAM] = 1'b1;
    end else begin
      sel_now[SLV_DEF] = 1'b1;
    end
  end

  // Select captured on the first cycle of an open bus cycle
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      cyc_q <= 1'b0;
      sel_q <= '0;
    end else begin
      cyc_q <= m_req_i.cyc;
      if (m_req_i.cyc && !cyc_q) begin
        sel_q <= sel_now;
      end
    end
  end

  // First cycle uses the live decode, later cycles the held copy
  assign sel = (m_req_i.cyc && cyc_q) ? sel_q : sel_now;

  // Same request to every slave, strobes only to the chosen one
  always_comb begin
    ram_req_o     = m_req_i;
    ram_req_o.cyc = m_req_i.cyc & sel[SLV_RAM];
    ram_req_o.stb = m_req_i.stb & sel[SLV_RAM];
  end

  always_comb begin
    gpio_req_o     = m_req_i;
    gpio_req_o.cyc = m_req_i.cyc & sel[SLV_GPIO];
    gpio_req_o.stb = m_req_i.stb & sel[SLV_GPIO];
  end

  // Default slave acks at once
  assign def_ack = m_req_i.cyc & m_req_i.stb & sel[SLV_DEF];

  // Response back to the master
  always_comb begin
    m_rsp_o = '0;
    if (sel[SLV_GPIO]) begin
      m_rsp_o = gpio_rsp_i;
    end else if (sel[SLV_RAM]) begin
      m_rsp_o = ram_rsp_i;
    end else if (sel[SLV_DEF]) begin
      m_rsp_o.dat = '1;
      m_rsp_o.ack = def_ack;
    end
  end

endmodule

`default_nettype wire

//--- rtl/gpio_regs.sv
// Switch input register and LED output register as a bus slave
`timescale 1ns/1ps
`default_nettype none

module gpio_regs import soc_bus_pkg::*; (
  input  logic     clk,
  input  logic     rst_n_i,
  input  bus_req_t req_i,
  output bus_rsp_t rsp_o,
  input  sw_t      sw_i,
  output leds_t    leds_o
);

  sw_t   sw_q;
  leds_t leds_q;
  data_t rd_q;
  logic  ack_q;
  logic  access;

  // One access per request, the ack cycle does not retrigger
  assign access = req_i.cyc & req_i.stb & ~ack_q;

  always_ff @(posedge clk) begin
    sw_q <= sw_i;
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ack_q  <= 1'b0;
      leds_q <= '0;
    end else begin
      ack_q <= access;
      // Offset 1 is the LED register, offset 0 ignores writes
      if (access && req_i.we && req_i.adr[0]) begin
        if (req_i.sel[0]) leds_q[7:0]  <= req_i.dat[7:0];
        if (req_i.sel[1]) leds_q[13:8] <= req_i.dat[13:8];
      end
    end
  end

  // Read data
  always_ff @(posedge clk) begin
    if (access) begin
      rd_q <= req_i.adr[0] ? data_t'(leds_q) : data_t'(sw_q);
    end
  end

  assign rsp_o.dat = rd_q;
  assign rsp_o.ack = ack_q;
  assign leds_o    = leds_q;

endmodule

`default_nettype wire

//--- rtl/word_ram.sv
// On-chip word memory with byte-lane writes as a bus slave
`timescale 1ns/1ps
`default_nettype none

module word_ram import soc_bus_pkg::*; #(
  parameter int RAM_ADDR_BITS = 8
) (
  input  logic     clk,
  input  logic     rst_n_i,
  input  bus_req_t req_i,
  output bus_rsp_t rsp_o
);

  data_t                    mem [2**RAM_ADDR_BITS];
  logic [RAM_ADDR_BITS-1:0] idx;
  data_t                    rd_q;
  logic                     ack_q;
  logic                     access;

  // Higher address bits alias onto the same words
  assign idx    = req_i.adr[RAM_ADDR_BITS-1:0];
  assign access = req_i.cyc & req_i.stb & ~ack_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // Byte writes and registered read
  always_ff @(posedge clk) begin
    if (access) begin
      if (req_i.we && req_i.sel[0]) mem[idx][7:0]  <= req_i.dat[7:0];
      if (req_i.we && req_i.sel[1]) mem[idx][15:8] <= req_i.dat[15:8];
      rd_q <= mem[idx];
    end
  end

  assign rsp_o.dat = rd_q;
  assign rsp_o.ack = ack_q;

endmodule

`default_nettype wire

//--- rtl/soc_bus_top.sv
// Top level with reset debouncer, bus switch, GPIO block and word memory
`timescale 1ns/1ps
`default_nettype none

module soc_bus_top import soc_bus_pkg::*; #(
  parameter int RST_COUNT_BITS = 17,
  parameter int RAM_ADDR_BITS  = 8
) (
  input  logic     clk,
  input  logic     rst_lck,
  input  bus_req_t m_req_i,
  output bus_rsp_t m_rsp_o,
  input  sw_t      sw_i,
  output leds_t    leds_o
);

  logic     rst_n_int;
  bus_req_t ram_req;
  bus_rsp_t ram_rsp;
  bus_req_t gpio_req;
  bus_rsp_t gpio_rsp;

  rst_debounce #(
    .RST_COUNT_BITS (RST_COUNT_BITS)
  ) u_rst_debounce (
    .clk         (clk),
    .rst_lck     (rst_lck),
    .rst_n_int_o (rst_n_int)
  );

  bus_switch u_bus_switch (
    .clk        (clk),
    .rst_n_i    (rst_n_int),
    .m_req_i    (m_req_i),
    .m_rsp_o    (m_rsp_o),
    .ram_req_o  (ram_req),
    .ram_rsp_i  (ram_rsp),
    .gpio_req_o (gpio_req),
    .gpio_rsp_i (gpio_rsp)
  );

  // Switches and LEDs
  gpio_regs u_gpio_regs (
    .clk     (clk),
    .rst_n_i (rst_n_int),
    .req_i   (gpio_req),
    .rsp_o   (gpio_rsp),
    .sw_i    (sw_i),
    .leds_o  (leds_o)
  );

  // Stands in for the SDRAM path
  word_ram #(
    .RAM_ADDR_BITS (RAM_ADDR_BITS)
  ) u_word_ram (
    .clk     (clk),
    .rst_n_i (rst_n_int),
    .req_i   (ram_req),
    .rsp_o   (ram_rsp)
  );

endmodule

`default_nettype wire

//--- verification/tb_clk_gen.sv
// Free-running testbench clock source
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter real PERIOD_NS = 8.0
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

//--- verification/soc_bus_tb.sv
// Testbench with bus master task, reference model, compare process and tests
`timescale 1ns/1ps
`default_nettype none

module soc_bus_tb import soc_bus_pkg::*; ();

  localparam int RAM_BITS    = 8;
  localparam int RAM_WORDS   = 1 << RAM_BITS;
  localparam int ACK_TIMEOUT = 64;
  // GPIO sits at I/O byte address 0xf100, switches then LEDs
  localparam word_adr_t GPIO_SW  = word_adr_t'(32'hf100 >> 1);
  localparam word_adr_t GPIO_LED = GPIO_SW | 19'd1;

  logic     clk;
  logic     rst_lck;
  bus_req_t m_req;
  bus_rsp_t m_rsp;
  sw_t      sw;
  leds_t    leds;

  // Reference model state
  data_t mem_model [RAM_WORDS];
  leds_t led_shadow;

  integer seed;
  int     checks;
  int     mismatches;
  int     timeouts;

  // Read in flight, picked up by the compare process
  logic  rd_busy;
  data_t rd_exp;
  string rd_name;

  tb_clk_gen #(
    .PERIOD_NS (8.0)
  ) u_clk_gen (
    .clk_o (clk)
  );

  soc_bus_top #(
    .RST_COUNT_BITS (4),
    .RAM_ADDR_BITS  (RAM_BITS)
  ) uut (
    .clk     (clk),
    .rst_lck (rst_lck),
    .m_req_i (m_req),
    .m_rsp_o (m_rsp),
    .sw_i    (sw),
    .leds_o  (leds)
  );

  function automatic logic in_gpio(logic io, word_adr_t adr);
    return io && (adr[18:1] == GPIO_SW[18:1]);
  endfunction

  // Expected read data by the window rule
  function automatic data_t expected_read(logic io, word_adr_t adr);
    if (in_gpio(io, adr)) begin
      return adr[0] ? data_t'(led_shadow) : data_t'(sw);
    end else if (!io) begin
      return mem_model[adr[RAM_BITS-1:0]];
    end
    return 16'hffff;
  endfunction

  task automatic model_write(input logic io, input word_adr_t adr, input data_t dat,
                             input sel_t sel);
    if (in_gpio(io, adr)) begin
      if (adr[0] && sel[0]) led_shadow[7:0] = dat[7:0];
      if (adr[0] && sel[1]) led_shadow[13:8] = dat[13:8];
    end else if (!io) begin
      if (sel[0]) mem_model[adr[RAM_BITS-1:0]][7:0] = dat[7:0];
      if (sel[1]) mem_model[adr[RAM_BITS-1:0]][15:8] = dat[15:8];
    end
  endtask

  task automatic check(input string name, input logic [15:0] exp, input logic [15:0] act);
    checks++;
    if (act !== exp) begin
      mismatches++;
      $display("mismatch %s expected %h actual %h", name, exp, act);
    end
  endtask

  // One master cycle, held until ack or timeout
  task automatic bus_cycle(input logic io, input word_adr_t adr, input logic we,
                           input data_t dat, input sel_t sel, input string name);
    int   n;
    logic got;
    @(posedge clk);
    #1;
    m_req.io  = io;
    m_req.adr = adr;
    m_req.dat = dat;
    m_req.sel = sel;
    m_req.we  = we;
    m_req.cyc = 1'b1;
    m_req.stb = 1'b1;
    if (!we) begin
      rd_exp  = expected_read(io, adr);
      rd_name = name;
      rd_busy = 1'b1;
    end
    got = 1'b0;
    n   = 0;
    while (!got && n < ACK_TIMEOUT) begin
      @(negedge clk);
      got = (m_rsp.ack === 1'b1);
      n++;
    end
    if (!got) begin
      timeouts++;
      $display("no acknowledge from the bus at io %0d word address %h in %s", io, adr, name);
    end else if (we) begin
      model_write(io, adr, dat, sel);
    end
    @(posedge clk);
    #1;
    // Registered slaves drop ack after one cycle while stb is still high
    if (got && (!io || in_gpio(io, adr))) begin
      check({name, "_ack_pulse"}, 16'h0000, 16'(m_rsp.ack));
    end
    m_req.cyc = 1'b0;
    m_req.stb = 1'b0;
    m_req.we  = 1'b0;
    rd_busy   = 1'b0;
  endtask

  // Read data is compared in the ack cycle
  always @(negedge clk) begin
    if (rd_busy && m_rsp.ack === 1'b1) begin
      check(rd_name, rd_exp, m_rsp.dat);
    end
  end

  initial begin
    int        i;
    word_adr_t a;
    data_t     d;
    sel_t      s;
    seed       = 32'h2b6b;
    checks     = 0;
    mismatches = 0;
    timeouts   = 0;
    rst_lck    = 1'b0;
    m_req      = '0;
    sw         = '0;
    led_shadow = '0;
    rd_busy    = 1'b0;
    rd_exp     = '0;
    rd_name    = "";
    repeat (8) @(posedge clk);
    #1;
    rst_lck = 1'b1;

    // First access waits out the debounce counter
    bus_cycle(1'b1, GPIO_LED, 1'b0, '0, 2'b11, "reset_leds_read");
    check("reset_leds_port", 16'h0000, data_t'(leds));

    // Fill pattern from the full word index
    for (i = 0; i < RAM_WORDS; i++) begin
      bus_cycle(1'b0, word_adr_t'(i), 1'b1, {~8'(i), 8'(i)}, 2'b11, "ram_fill");
    end
    for (i = 0; i < 48; i++) begin
      a = word_adr_t'($random(seed));
      d = data_t'($random(seed));
      s = sel_t'($random(seed));
      if (s == 2'b00) s = 2'b11;  // full word instead of a no-op
      bus_cycle(1'b0, a, 1'b1, d, s, "ram_write");
      // Same word through an aliased high address
      a[18:RAM_BITS] = ~a[18:RAM_BITS];
      bus_cycle(1'b0, a, 1'b0, '0, 2'b11, "ram_readback");
    end
    for (i = 0; i < RAM_WORDS; i++) begin
      bus_cycle(1'b0, word_adr_t'(i), 1'b0, '0, 2'b11, "ram_sweep");
    end

    // Switches, offset 0 is read only
    for (i = 0; i < 8; i++) begin
      sw = sw_t'($random(seed));
      bus_cycle(1'b1, GPIO_SW, 1'b0, '0, 2'b11, "gpio_switch_read");
    end
    bus_cycle(1'b1, GPIO_SW, 1'b1, 16'h5a5a, 2'b11, "gpio_switch_write");
    bus_cycle(1'b1, GPIO_SW, 1'b0, '0, 2'b11, "gpio_switch_after_write");
    for (i = 0; i < 12; i++) begin
      d = data_t'($random(seed));
      s = sel_t'($random(seed));
      bus_cycle(1'b1, GPIO_LED, 1'b1, d, s, "gpio_led_write");
      check("gpio_leds_port", data_t'(led_shadow), data_t'(leds));
      bus_cycle(1'b1, GPIO_LED, 1'b0, '0, 2'b11, "gpio_led_read");
    end

    // Unmapped I/O goes to the default slave
    for (i = 0; i < 24; i++) begin
      a = word_adr_t'($random(seed));
      if (a[18:1] == GPIO_SW[18:1]) a[5] = ~a[5];
      d = data_t'($random(seed));
      bus_cycle(1'b1, a, 1'b1, d, 2'b11, "default_write");
      bus_cycle(1'b1, a, 1'b0, '0, 2'b11, "default_read");
      bus_cycle(1'b0, a, 1'b0, '0, 2'b11, "default_ram_intact");
    end
    bus_cycle(1'b1, GPIO_SW - 19'd1, 1'b0, '0, 2'b11, "default_below_gpio");
    bus_cycle(1'b1, GPIO_SW + 19'd2, 1'b0, '0, 2'b11, "default_above_gpio");
    check("default_leds_port", data_t'(led_shadow), data_t'(leds));

    // Memory address 0xf100 is RAM, I/O 0xf100 is GPIO
    bus_cycle(1'b0, GPIO_SW, 1'b1, 16'hc3a5, 2'b11, "prio_ram_write");
    bus_cycle(1'b0, GPIO_LED, 1'b1, 16'h3c5a, 2'b11, "prio_ram_led_write");
    check("prio_leds_port", data_t'(led_shadow), data_t'(leds));
    bus_cycle(1'b0, GPIO_SW, 1'b0, '0, 2'b11, "prio_ram_read");
    bus_cycle(1'b0, GPIO_LED, 1'b0, '0, 2'b11, "prio_ram_led_read");
    bus_cycle(1'b1, GPIO_SW, 1'b0, '0, 2'b11, "prio_gpio_switch_read");
    bus_cycle(1'b1, GPIO_LED, 1'b0, '0, 2'b11, "prio_gpio_led_read");

    repeat (2) @(posedge clk);
    $display("checks %0d mismatches %0d timeouts %0d", checks, mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
rtl/soc_bus_pkg.sv
rtl/rst_debounce.sv
rtl/bus_switch.sv
rtl/gpio_regs.sv
rtl/word_ram.sv
rtl/soc_bus_top.sv
verification/tb_clk_gen.sv
verification/soc_bus_tb.sv
